//--- source/vec_alu_config.svh
// byte offsets assume word-aligned 32-bit AXI4-Lite accesses; FIFO depths must be at least 1
`ifndef VEC_ALU_CONFIG_SVH
`define VEC_ALU_CONFIG_SVH

`define VEC_AXI_DATA_W 32
`define VEC_AXI_ADDR_W 5

`define VEC_CMD_DEPTH 4
`define VEC_RES_DEPTH 4

`define VEC_REG_VS1_LO 5'h00
`define VEC_REG_VS1_HI 5'h04
`define VEC_REG_VS2_LO 5'h08
`define VEC_REG_VS2_HI 5'h0C
`define VEC_REG_CTRL   5'h10
`define VEC_REG_STATUS 5'h14
`define VEC_REG_RES_LO 5'h18
`define VEC_REG_RES_HI 5'h1C

`endif

//--- source/vec_alu_pkg.sv
// shared types only; op codes 10 to 31 are reserved and the execute unit returns zero for them
package vec_alu_pkg;

    typedef logic [63:0] bus64_t;   // one register slice, operand or result

    // vector integer operations handled by the execute unit
    typedef enum logic [4:0] {
        VADD  = 5'd0,
        VSUB  = 5'd1,
        VRSUB = 5'd2,   // vs1 - vs2
        VADC  = 5'd3,
        VSBC  = 5'd4,
        VMADC = 5'd5,
        VMSBC = 5'd6,
        VAND  = 5'd7,
        VOR   = 5'd8,
        VXOR  = 5'd9
    } vop_t;

    // element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // one queued operation, operands captured at the CTRL write
    typedef struct packed {
        vop_t       op;
        sew_t       sew;
        logic       use_mask;
        logic [7:0] vm;         // bit i belongs to element i
        bus64_t     vs1;
        bus64_t     vs2;
    } vcmd_t;

endpackage

//--- source/vaddsub.sv
`timescale 1ns/1ps
// purely combinational; output for bitwise or reserved op codes is meaningless and muxed off upstream
module vaddsub (
    input  vec_alu_pkg::vop_t   op_i,
    input  vec_alu_pkg::sew_t   sew_i,
    input  vec_alu_pkg::bus64_t vs1_i,
    input  vec_alu_pkg::bus64_t vs2_i,
    input  logic [7:0]          vm_i,
    input  logic                use_mask_i,
    output vec_alu_pkg::bus64_t vd_o
);

    logic            inv_vs1;       // vs2 - vs1 style ops
    logic            inv_vs2;       // vrsub
    logic            mask_op;       // vmadc / vmsbc
    logic            is_vmsbc;
    logic [2:0]      lane_mask;     // byte index bits that stay inside one element
    logic [7:0]      elem_cin;      // carry into the low byte of element e
    logic [7:0][7:0] opa;
    logic [7:0][7:0] opb;
    logic [7:0][8:0] byte_sum;      // byte result plus its carry out
    logic [7:0][7:0] sum_bytes;
    logic [7:0]      mask_bits;

    assign inv_vs1  = (op_i == vec_alu_pkg::VSUB) || (op_i == vec_alu_pkg::VSBC) ||
                      (op_i == vec_alu_pkg::VMSBC);
    assign inv_vs2  = (op_i == vec_alu_pkg::VRSUB);
    assign is_vmsbc = (op_i == vec_alu_pkg::VMSBC);
    assign mask_op  = (op_i == vec_alu_pkg::VMADC) || is_vmsbc;

    // two's complement through inversion, the +1 arrives as carry in
    assign opa = inv_vs2 ? ~vs2_i : vs2_i;
    assign opb = inv_vs1 ? ~vs1_i : vs1_i;

    always_comb begin
        case (sew_i)
            vec_alu_pkg::SEW_8:  lane_mask = 3'd0;
            vec_alu_pkg::SEW_16: lane_mask = 3'd1;
            vec_alu_pkg::SEW_32: lane_mask = 3'd3;
            default:             lane_mask = 3'd7;
        endcase
    end

    // per element carry in
    // a - b - borrow equals a + ~b + ~borrow, so vsbc and vmsbc feed the inverted mask bit
    always_comb begin
        for (int e = 0; e < 8; e++) begin
            case (op_i)
                vec_alu_pkg::VSUB,
                vec_alu_pkg::VRSUB: elem_cin[e] = 1'b1;
                vec_alu_pkg::VSBC:  elem_cin[e] = ~vm_i[e];
                vec_alu_pkg::VMSBC: elem_cin[e] = ~(use_mask_i & vm_i[e]);
                vec_alu_pkg::VADC:  elem_cin[e] = vm_i[e];
                vec_alu_pkg::VMADC: elem_cin[e] = use_mask_i & vm_i[e];
                default:            elem_cin[e] = 1'b0;
            endcase
        end
    end

    // one ripple chain over eight 9-bit byte adders, restarted at each element's low byte
    always_comb begin
        logic carry;
        carry     = 1'b0;
        mask_bits = '1;             // unused element slots read as one
        for (int i = 0; i < 8; i++) begin
            if ((3'(i) & lane_mask) == 3'd0)
                carry = elem_cin[i >> sew_i];
            byte_sum[i]  = {1'b0, opa[i]} + {1'b0, opb[i]} + 9'(carry);
            sum_bytes[i] = byte_sum[i][7:0];
            carry        = byte_sum[i][8];
            // top byte of an element, its carry out is the element's mask result
            // for vmsbc no carry out means vs1 + borrow exceeds vs2
            if ((3'(i) & lane_mask) == lane_mask)
                mask_bits[i >> sew_i] = is_vmsbc ? ~carry : carry;
        end
    end

    assign vd_o = mask_op ? {{56{1'b1}}, mask_bits} : sum_bytes;

endmodule

//--- source/vec_fifo.sv
`timescale 1ns/1ps
// first-word-fall-through FIFO; a push into a full FIFO is dropped unless a pop happens that cycle
module vec_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       push_i,
    input  payload_t                   data_i,
    input  logic                       pop_i,
    output payload_t                   data_o,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic          do_push;
    logic          do_pop;

    assign full_o  = (count_o == CW'(DEPTH));
    assign empty_o = (count_o == '0);
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);  // full FIFO still takes a push beside a pop
    assign data_o  = mem[rd_ptr];                   // head entry, valid while not empty

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count_o <= count_o + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push)
            mem[wr_ptr] <= data_i;
    end

endmodule

//--- source/vec_exec.sv
`timescale 1ns/1ps
// single stage; a full result FIFO holds the output register and stops command pops
module vec_exec (
    input  logic                clk_i,
    input  logic                reset_i,
    input  vec_alu_pkg::vcmd_t  cmd_i,
    input  logic                cmd_empty_i,
    output logic                cmd_pop_o,
    input  logic                res_full_i,
    output logic                res_push_o,
    output vec_alu_pkg::bus64_t res_o
);

    vec_alu_pkg::bus64_t arith;
    vec_alu_pkg::bus64_t result;
    logic                res_valid;     // output register holds a result

    vaddsub u_vaddsub (
        .op_i       (cmd_i.op),
        .sew_i      (cmd_i.sew),
        .vs1_i      (cmd_i.vs1),
        .vs2_i      (cmd_i.vs2),
        .vm_i       (cmd_i.vm),
        .use_mask_i (cmd_i.use_mask),
        .vd_o       (arith)
    );

    always_comb begin
        case (cmd_i.op)
            vec_alu_pkg::VADD,  vec_alu_pkg::VSUB,
            vec_alu_pkg::VRSUB, vec_alu_pkg::VADC,
            vec_alu_pkg::VSBC,  vec_alu_pkg::VMADC,
            vec_alu_pkg::VMSBC: result = arith;
            vec_alu_pkg::VAND:  result = cmd_i.vs1 & cmd_i.vs2;
            vec_alu_pkg::VOR:   result = cmd_i.vs1 | cmd_i.vs2;
            vec_alu_pkg::VXOR:  result = cmd_i.vs1 ^ cmd_i.vs2;
            default:            result = '0;   // reserved codes
        endcase
    end

    assign res_push_o = res_valid & ~res_full_i;
    // refill in the same cycle the held result moves on
    assign cmd_pop_o  = ~cmd_empty_i & (~res_valid | res_push_o);

    always_ff @(posedge clk_i) begin
        if (reset_i)
            res_valid <= 1'b0;
        else if (cmd_pop_o)
            res_valid <= 1'b1;
        else if (res_push_o)
            res_valid <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (cmd_pop_o)
            res_o <= result;
    end

endmodule

//--- source/vec_axil_regs.sv
`timescale 1ns/1ps
// one write and one read outstanding at a time; CTRL ignores byte strobes and takes the whole word
`include "vec_alu_config.svh"

module vec_axil_regs (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [`VEC_AXI_ADDR_W-1:0]          s_awaddr_i,
    input  logic                                s_awvalid_i,
    output logic                                s_awready_o,
    input  logic [`VEC_AXI_DATA_W-1:0]          s_wdata_i,
    input  logic [`VEC_AXI_DATA_W/8-1:0]        s_wstrb_i,
    input  logic                                s_wvalid_i,
    output logic                                s_wready_o,
    output logic [1:0]                          s_bresp_o,
    output logic                                s_bvalid_o,
    input  logic                                s_bready_i,
    input  logic [`VEC_AXI_ADDR_W-1:0]          s_araddr_i,
    input  logic                                s_arvalid_i,
    output logic                                s_arready_o,
    output logic [`VEC_AXI_DATA_W-1:0]          s_rdata_o,
    output logic [1:0]                          s_rresp_o,
    output logic                                s_rvalid_o,
    input  logic                                s_rready_i,
    input  logic                                cmd_full_i,
    output logic                                cmd_push_o,
    output vec_alu_pkg::vcmd_t                  cmd_o,
    input  vec_alu_pkg::bus64_t                 res_i,
    input  logic                                res_empty_i,
    input  logic [$clog2(`VEC_RES_DEPTH+1)-1:0] res_count_i,
    output logic                                res_pop_o
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    vec_alu_pkg::bus64_t        vs1_q;
    vec_alu_pkg::bus64_t        vs2_q;
    logic                       wr_ctrl;
    logic                       wr_en;
    logic                       wr_ok;
    logic                       rd_en;
    logic                       rd_ok;
    logic [`VEC_AXI_DATA_W-1:0] rd_data;
    logic [`VEC_AXI_DATA_W-1:0] status_word;

    assign wr_ctrl = (s_awaddr_i == `VEC_REG_CTRL);
    // AW and W taken together, held off while B is pending or CTRL meets a full FIFO
    assign wr_en       = s_awvalid_i & s_wvalid_i & ~s_bvalid_o & ~(wr_ctrl & cmd_full_i);
    assign s_awready_o = wr_en;
    assign s_wready_o  = wr_en;

    always_comb begin
        case (s_awaddr_i)
            `VEC_REG_VS1_LO, `VEC_REG_VS1_HI,
            `VEC_REG_VS2_LO, `VEC_REG_VS2_HI,
            `VEC_REG_CTRL:   wr_ok = 1'b1;
            default:         wr_ok = 1'b0;   // read-only or unmapped
        endcase
    end

    // operand registers, byte strobed
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vs1_q <= '0;
            vs2_q <= '0;
        end else if (wr_en) begin
            for (int b = 0; b < `VEC_AXI_DATA_W / 8; b++) begin
                if (s_wstrb_i[b]) begin
                    case (s_awaddr_i)
                        `VEC_REG_VS1_LO: vs1_q[8*b +: 8]      <= s_wdata_i[8*b +: 8];
                        `VEC_REG_VS1_HI: vs1_q[32 + 8*b +: 8] <= s_wdata_i[8*b +: 8];
                        `VEC_REG_VS2_LO: vs2_q[8*b +: 8]      <= s_wdata_i[8*b +: 8];
                        `VEC_REG_VS2_HI: vs2_q[32 + 8*b +: 8] <= s_wdata_i[8*b +: 8];
                        default: ;
                    endcase
                end
            end
        end
    end

    // command built from the CTRL word and the operands as they stand
    assign cmd_push_o     = wr_en & wr_ctrl;
    assign cmd_o.op       = vec_alu_pkg::vop_t'(s_wdata_i[4:0]);
    assign cmd_o.sew      = vec_alu_pkg::sew_t'(s_wdata_i[6:5]);
    assign cmd_o.use_mask = s_wdata_i[7];
    assign cmd_o.vm       = s_wdata_i[15:8];
    assign cmd_o.vs1      = vs1_q;
    assign cmd_o.vs2      = vs2_q;

    always_ff @(posedge clk_i) begin
        if (reset_i)
            s_bvalid_o <= 1'b0;
        else if (wr_en)
            s_bvalid_o <= 1'b1;
        else if (s_bready_i)
            s_bvalid_o <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (wr_en)
            s_bresp_o <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end

    assign s_arready_o = ~s_rvalid_o;
    assign rd_en       = s_arvalid_i & s_arready_o;
    assign status_word = {23'd0, cmd_full_i, 4'd0, 4'(res_count_i)};

    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (s_araddr_i)
            `VEC_REG_VS1_LO: rd_data = vs1_q[31:0];
            `VEC_REG_VS1_HI: rd_data = vs1_q[63:32];
            `VEC_REG_VS2_LO: rd_data = vs2_q[31:0];
            `VEC_REG_VS2_HI: rd_data = vs2_q[63:32];
            `VEC_REG_STATUS: rd_data = status_word;
            `VEC_REG_RES_LO,
            `VEC_REG_RES_HI: begin
                rd_ok = ~res_empty_i;  // empty result FIFO gives SLVERR with zero data
                if (!res_empty_i)
                    rd_data = (s_araddr_i == `VEC_REG_RES_HI) ? res_i[63:32] : res_i[31:0];
            end
            default:         rd_ok = 1'b0;   // CTRL is write only
        endcase
    end

    assign res_pop_o = rd_en & (s_araddr_i == `VEC_REG_RES_HI) & ~res_empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i)
            s_rvalid_o <= 1'b0;
        else if (rd_en)
            s_rvalid_o <= 1'b1;
        else if (s_rready_i)
            s_rvalid_o <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            s_rdata_o <= rd_data;
            s_rresp_o <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- source/vec_alu_top.sv
`timescale 1ns/1ps
// AXI4-Lite vector ALU; read RES_LO before RES_HI since the RES_HI read pops the result
`include "vec_alu_config.svh"

module vec_alu_top (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic [`VEC_AXI_ADDR_W-1:0]   s_awaddr_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,
    input  logic [`VEC_AXI_DATA_W-1:0]   s_wdata_i,
    input  logic [`VEC_AXI_DATA_W/8-1:0] s_wstrb_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,
    output logic [1:0]                   s_bresp_o,
    output logic                         s_bvalid_o,
    input  logic                         s_bready_i,
    input  logic [`VEC_AXI_ADDR_W-1:0]   s_araddr_i,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,
    output logic [`VEC_AXI_DATA_W-1:0]   s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    output logic                         s_rvalid_o,
    input  logic                         s_rready_i
);

    vec_alu_pkg::vcmd_t                  cmd_wr;
    vec_alu_pkg::vcmd_t                  cmd_head;
    logic                                cmd_push;
    logic                                cmd_pop;
    logic                                cmd_full;
    logic                                cmd_empty;
    vec_alu_pkg::bus64_t                 res_wr;
    vec_alu_pkg::bus64_t                 res_head;
    logic                                res_push;
    logic                                res_pop;
    logic                                res_full;
    logic                                res_empty;
    logic [$clog2(`VEC_RES_DEPTH+1)-1:0] res_count;

    vec_axil_regs u_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .cmd_full_i  (cmd_full),
        .cmd_push_o  (cmd_push),
        .cmd_o       (cmd_wr),
        .res_i       (res_head),
        .res_empty_i (res_empty),
        .res_count_i (res_count),
        .res_pop_o   (res_pop)
    );

    vec_fifo #(
        .payload_t (vec_alu_pkg::vcmd_t),
        .DEPTH     (`VEC_CMD_DEPTH)
    ) u_cmd_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (cmd_push),
        .data_i  (cmd_wr),
        .pop_i   (cmd_pop),
        .data_o  (cmd_head),
        .full_o  (cmd_full),
        .empty_o (cmd_empty),
        .count_o ()
    );

    vec_exec u_exec (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_i       (cmd_head),
        .cmd_empty_i (cmd_empty),
        .cmd_pop_o   (cmd_pop),
        .res_full_i  (res_full),
        .res_push_o  (res_push),
        .res_o       (res_wr)
    );

    vec_fifo #(
        .payload_t (vec_alu_pkg::bus64_t),
        .DEPTH     (`VEC_RES_DEPTH)
    ) u_res_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (res_push),
        .data_i  (res_wr),
        .pop_i   (res_pop),
        .data_o  (res_head),
        .full_o  (res_full),
        .empty_o (res_empty),
        .count_o (res_count)
    );

endmodule

//--- verif/vec_alu_chk.sv
`timescale 1ns/1ps
// bound into vec_alu_top; all checks except the reset one are off while reset_i is high
module vec_alu_chk (
    input logic        clk_i,
    input logic        reset_i,
    input logic        awvalid_i,
    input logic        awready_i,
    input logic [4:0]  awaddr_i,
    input logic        wvalid_i,
    input logic        wready_i,
    input logic [31:0] wdata_i,
    input logic        bvalid_i,
    input logic        bready_i,
    input logic [1:0]  bresp_i,
    input logic        arvalid_i,
    input logic        arready_i,
    input logic [4:0]  araddr_i,
    input logic        rvalid_i,
    input logic        rready_i,
    input logic [31:0] rdata_i,
    input logic [1:0]  rresp_i,
    input logic        cmd_pop_i,
    input logic        res_push_i,
    input logic        res_full_i
);

    int fail_count = 0;

    reset_clear: assert property (@(posedge clk_i)
        reset_i |=> !bvalid_i && !rvalid_i && !res_push_i)
        else begin fail_count++; $error("valid or push high after reset"); end

    // host side holds address and data until the slave takes them
    aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        awvalid_i && !awready_i |=> awvalid_i && wvalid_i && $stable(awaddr_i) && $stable(wdata_i))
        else begin fail_count++; $error("write request changed before handshake"); end

    ar_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin fail_count++; $error("read request changed before handshake"); end

    b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
        else begin fail_count++; $error("write response dropped or changed"); end

    r_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
        else begin fail_count++; $error("read response dropped or changed"); end

    pop_to_push: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_pop_i |=> res_push_i || res_full_i)
        else begin fail_count++; $error("no result push one cycle after command pop"); end

endmodule

bind vec_alu_top vec_alu_chk u_chk (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .awvalid_i  (s_awvalid_i),
    .awready_i  (s_awready_o),
    .awaddr_i   (s_awaddr_i),
    .wvalid_i   (s_wvalid_i),
    .wready_i   (s_wready_o),
    .wdata_i    (s_wdata_i),
    .bvalid_i   (s_bvalid_o),
    .bready_i   (s_bready_i),
    .bresp_i    (s_bresp_o),
    .arvalid_i  (s_arvalid_i),
    .arready_i  (s_arready_o),
    .araddr_i   (s_araddr_i),
    .rvalid_i   (s_rvalid_o),
    .rready_i   (s_rready_i),
    .rdata_i    (s_rdata_o),
    .rresp_i    (s_rresp_o),
    .cmd_pop_i  (cmd_pop),
    .res_push_i (res_push),
    .res_full_i (res_full)
);

//--- verif/vec_alu_tb.sv
`timescale 1ns/1ps
// drives the AXI4-Lite port only; results are fetched after STATUS shows a nonzero count
`include "vec_alu_config.svh"

module vec_alu_tb;

    localparam int N_OPS = 62;          // operations issued over the whole run
    localparam logic [4:0] ARITH_OPS [3] = '{vec_alu_pkg::VADD, vec_alu_pkg::VSUB,
                                             vec_alu_pkg::VRSUB};
    localparam logic [4:0] BIT_OPS [4] = '{vec_alu_pkg::VAND, vec_alu_pkg::VOR,
                                           vec_alu_pkg::VXOR, 5'd20};

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic [4:0]  s_awaddr_i;
    logic        s_awvalid_i;
    logic        s_awready_o;
    logic [31:0] s_wdata_i;
    logic [3:0]  s_wstrb_i;
    logic        s_wvalid_i;
    logic        s_wready_o;
    logic [1:0]  s_bresp_o;
    logic        s_bvalid_o;
    logic        s_bready_i;
    logic [4:0]  s_araddr_i;
    logic        s_arvalid_i;
    logic        s_arready_o;
    logic [31:0] s_rdata_o;
    logic [1:0]  s_rresp_o;
    logic        s_rvalid_o;
    logic        s_rready_i;

    logic [31:0] rng_state = 32'h3eb8_eaae;
    logic [63:0] expected_q [$];        // expected results in issue order
    int          errors = 0;
    int          asrt_fails;

    vec_alu_top UUT (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [63:0] rand64();
        return {xorshift32(), xorshift32()};
    endfunction

    // element by element, one bit wider than needed so carries and borrows show up
    function automatic logic [63:0] model_result(input logic [4:0] op, input logic [1:0] sew,
            input logic use_mask, input logic [7:0] vm, input logic [63:0] vs1,
            input logic [63:0] vs2);
        int unsigned ew;
        logic [65:0] emask;
        logic [65:0] a;
        logic [65:0] b;
        logic [65:0] r;
        logic [65:0] bw;
        logic [63:0] res;
        ew    = 8 << sew;
        emask = (66'd1 << ew) - 66'd1;
        res   = (op == vec_alu_pkg::VMADC || op == vec_alu_pkg::VMSBC) ? '1 : '0;
        for (int e = 0; e < 64 / ew; e++) begin
            a  = (66'(vs1) >> (e * ew)) & emask;
            b  = (66'(vs2) >> (e * ew)) & emask;
            bw = 66'(use_mask & vm[e]);
            r  = '0;
            case (op)
                vec_alu_pkg::VADD:  r = b + a;
                vec_alu_pkg::VSUB:  r = b - a;
                vec_alu_pkg::VRSUB: r = a - b;
                vec_alu_pkg::VADC:  r = b + a + 66'(vm[e]);
                vec_alu_pkg::VSBC:  r = b - a - 66'(vm[e]);
                vec_alu_pkg::VMADC: res[e] = ((b + a + bw) >> ew) != 0;
                vec_alu_pkg::VMSBC: res[e] = (a + bw) > b;
                default: ;
            endcase
            if (op inside {vec_alu_pkg::VADD, vec_alu_pkg::VSUB, vec_alu_pkg::VRSUB,
                           vec_alu_pkg::VADC, vec_alu_pkg::VSBC})
                res |= 64'((r & emask) << (e * ew));
        end
        case (op)
            vec_alu_pkg::VAND: res = vs1 & vs2;
            vec_alu_pkg::VOR:  res = vs1 | vs2;
            vec_alu_pkg::VXOR: res = vs1 ^ vs2;
            default: ;
        endcase
        return res;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic       hs;
        logic [1:0] rdy;
        s_awaddr_i  = addr;
        s_wdata_i   = data;
        s_awvalid_i = 1'b1;
        s_wvalid_i  = 1'b1;
        hs  = 1'b0;
        rdy = '0;
        while (!hs) begin
            @(negedge clk_i);
            rdy = {s_awready_o, s_wready_o};
            hs  = |rdy;         // transfer happens at the next rising edge
            @(posedge clk_i);
            #1;
        end
        compare_value("{s_awready_o, s_wready_o}", 64'd3, 64'(rdy));  // AW and W go together
        s_awvalid_i = 1'b0;
        s_wvalid_i  = 1'b0;
        @(posedge clk_i);       // response waits one cycle for bready
        #1;
        s_bready_i  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk_i);
            hs   = s_bvalid_o;
            resp = s_bresp_o;
            @(posedge clk_i);
            #1;
        end
        s_bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        logic hs;
        s_araddr_i  = addr;
        s_arvalid_i = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk_i);
            hs = s_arready_o;
            @(posedge clk_i);
            #1;
        end
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk_i);
            hs   = s_rvalid_o;
            data = s_rdata_o;
            resp = s_rresp_o;
            @(posedge clk_i);
            #1;
        end
        s_rready_i = 1'b0;
    endtask

    // second AR is raised while the first R still waits for rready
    task automatic read_back_to_back(input logic [4:0] addr_a, input logic [4:0] addr_b,
                                     output logic [31:0] data_a, output logic [31:0] data_b);
        logic       hs;
        logic [1:0] resp;
        s_araddr_i  = addr_a;
        s_arvalid_i = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk_i);
            hs = s_arready_o;
            @(posedge clk_i);
            #1;
        end
        s_araddr_i = addr_b;    // arready stays low until the first R is taken
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk_i);
            hs     = s_rvalid_o;
            data_a = s_rdata_o;
            @(posedge clk_i);
            #1;
        end
        s_rready_i = 1'b1;
        read_reg(addr_b, data_b, resp);
    endtask

    task automatic issue_op(input logic [4:0] op, input logic [1:0] sew, input logic use_mask,
                            input logic [7:0] vm, input logic [63:0] vs1, input logic [63:0] vs2);
        logic [1:0] resp;
        write_reg(`VEC_REG_VS1_LO, vs1[31:0], resp);
        write_reg(`VEC_REG_VS1_HI, vs1[63:32], resp);
        write_reg(`VEC_REG_VS2_LO, vs2[31:0], resp);
        write_reg(`VEC_REG_VS2_HI, vs2[63:32], resp);
        write_reg(`VEC_REG_CTRL, {16'd0, vm, use_mask, sew, op}, resp);
        compare_value("s_bresp_o", 64'd0, 64'(resp));
        expected_q.push_back(model_result(op, sew, use_mask, vm, vs1, vs2));
    endtask

    // waits on the STATUS count, then pops one result and checks it against the queue head
    task automatic check_next();
        logic [31:0] stat;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [1:0]  resp;
        stat = '0;
        while (stat[3:0] == 4'd0)
            read_reg(`VEC_REG_STATUS, stat, resp);
        read_reg(`VEC_REG_RES_LO, lo, resp);
        read_reg(`VEC_REG_RES_HI, hi, resp);
        compare_value("result", expected_q.pop_front(), {hi, lo});
    endtask

    task automatic run_op(input logic [4:0] op, input logic [1:0] sew, input logic use_mask,
                          input logic [7:0] vm, input logic [63:0] vs1, input logic [63:0] vs2);
        issue_op(op, sew, use_mask, vm, vs1, vs2);
        check_next();
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] d2;
        logic [1:0]  resp;
        bit          stall_done;
        reset_i     = 1'b1;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = 4'hf;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        stall_done  = 1'b0;
        repeat (3) @(posedge clk_i);
        #1 reset_i = 1'b0;

        read_back_to_back(`VEC_REG_STATUS, `VEC_REG_VS1_LO, d, d2);
        compare_value("status", 64'd0, 64'(d));
        compare_value("vs1_lo", 64'd0, 64'(d2));

        // empty result FIFO and a read-only target
        read_reg(`VEC_REG_RES_LO, d, resp);
        compare_value("s_rresp_o", 64'd2, 64'(resp));
        compare_value("s_rdata_o", 64'd0, 64'(d));
        write_reg(`VEC_REG_STATUS, 32'h1234_5678, resp);
        compare_value("s_bresp_o", 64'd2, 64'(resp));

        for (int o = 0; o < 3; o++) begin
            for (int s = 0; s < 4; s++) begin
                run_op(ARITH_OPS[o], 2'(s), 1'b0, 8'h00, rand64(), rand64());
                run_op(ARITH_OPS[o], 2'(s), 1'b0, 8'h00, '1, '1);   // carry through every byte
            end
        end

        for (int s = 0; s < 4; s++) begin
            run_op(vec_alu_pkg::VADC, 2'(s), 1'b0, 8'(xorshift32()), rand64(), rand64());
            run_op(vec_alu_pkg::VSBC, 2'(s), 1'b0, 8'(xorshift32()), rand64(), rand64());
            for (int m = 0; m < 2; m++) begin
                run_op(vec_alu_pkg::VMADC, 2'(s), 1'(m), 8'(xorshift32()), rand64(), rand64());
                run_op(vec_alu_pkg::VMSBC, 2'(s), 1'(m), 8'(xorshift32()), rand64(), rand64());
            end
        end

        for (int o = 0; o < 4; o++)
            run_op(BIT_OPS[o], 2'd0, 1'b0, 8'h00, rand64(), rand64());

        // fill command FIFO, execute register and result FIFO without reading
        for (int k = 0; k < 9; k++)
            issue_op(5'(k % 10), 2'(k % 4), 1'(k % 2), 8'(xorshift32()), rand64(), rand64());
        fork
            begin
                issue_op(vec_alu_pkg::VADD, 2'd1, 1'b0, 8'h00, rand64(), rand64());
                stall_done = 1'b1;
            end
            begin
                repeat (40) @(posedge clk_i);
                #1;
                assert (!stall_done) else begin
                    errors++;
                    $display("command write was accepted while the command FIFO was full");
                end
                read_reg(`VEC_REG_STATUS, d, resp);
                compare_value("status", 64'h104, 64'(d));    // full flag, four results
                check_next();
            end
        join
        repeat (9) check_next();

        asrt_fails = UUT.u_chk.fail_count;
        $display("errors: %0d, assertion failures: %0d", errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (N_OPS * 200 + 1000) @(posedge clk_i);
        $display("timeout: the run did not finish in %0d cycles", N_OPS * 200 + 1000);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/vec_alu_pkg.sv
source/vaddsub.sv
source/vec_fifo.sv
source/vec_exec.sv
source/vec_axil_regs.sv
source/vec_alu_top.sv
verif/vec_alu_chk.sv
verif/vec_alu_tb.sv

//--- Bender.yml
package:
  name: vec_alu

export_include_dirs:
  - source

sources:
  - files:
      - source/vec_alu_pkg.sv
      - source/vaddsub.sv
      - source/vec_fifo.sv
      - source/vec_exec.sv
      - source/vec_axil_regs.sv
      - source/vec_alu_top.sv
  - target: test
    files:
      - verif/vec_alu_chk.sv
      - verif/vec_alu_tb.sv
